// ==== project.f ====
+incdir+common
common/ccu_pkg.sv
ccu/ccu_port_arb.sv
ccu/ccu_req_fifo.sv
ccu/ccu_fsm.sv
hdl/ccu_top.sv
test/tb_clock.sv
test/ccu_tb.sv

// ==== Makefile ====
# Verilator build and run of the coherency unit testbench
# The result is read back from the simulation log

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f project.f --top-module ccu_tb -Mdir obj_dir -o ccu_sim
	./obj_dir/ccu_sim 2>&1 | tee $(LOG)
	@grep -q "Verification passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== test/ccu_tb.sv ====
// Testbench for the coherency unit with models of dirty master lines and a slow memory
// Expected responses, snoops and memory requests are predicted at acceptance time
`timescale 1ns/1ps
`include "ccu_cfg.svh"

module ccu_tb;

  import ccu_pkg::*;

  localparam int N             = `CCU_NUM_PORTS;
  localparam int RAND_PER_PORT = 5;
  localparam int NUM_REQS      = 8 + N * (1 + RAND_PER_PORT);
  localparam int HOLD_ACCEPTS  = `CCU_FIFO_DEPTH + 1;  // One in service plus a full queue
  localparam longint TIMEOUT_NS = longint'(10 + 200 * NUM_REQS) * 100;

  typedef struct packed {
    logic [N-1:0] mask;  // Ports that must see the snoop
    snoop_req_t   req;
  } snp_exp_t;

  logic                  clk_i;
  logic                  rst_i;
  logic [N-1:0]          req_valid_i = '0;
  port_req_t [N-1:0]     req_i = '0;
  logic [N-1:0]          req_ready_o;
  logic [N-1:0]          resp_valid_o;
  port_resp_t            resp_o;
  logic [N-1:0]          snp_valid_o;
  snoop_req_t            snp_o;
  logic [N-1:0]          snp_resp_valid_i = '0;
  snoop_resp_t [N-1:0]   snp_resp_i = '0;
  logic                  mem_valid_o;
  mem_req_t              mem_req_o;
  logic                  mem_ready_i = 1'b0;
  logic                  mem_resp_valid_i = 1'b0;
  data_t                 mem_rdata_i = '0;

  data_t       mem_model [addr_t];
  data_t       ref_mem [addr_t];
  data_t       line_dirty [N][addr_t];  // Dirty lines held by each master
  data_t       ref_line [N][addr_t];
  port_req_t   stim_q [N][$];
  port_resp_t  exp_resp [N][$];
  snp_exp_t    exp_snp [$];
  mem_req_t    exp_mem [$];
  int          stim_rd [N] = '{default: 0};
  logic [N-1:0] accepted = '0;
  logic [N-1:0] snp_due = '0;
  snoop_resp_t [N-1:0] snp_next = '0;
  logic        mem_due = 1'b0;
  data_t       mem_rdata_q = '0;
  int unsigned stall = 0;
  logic        hold_mem = 1'b0;
  logic        saw_full = 1'b0;
  int          held_acc = 0;
  int          issued_cnt = 0;
  int          done_cnt = 0;
  integer      seed = 25877;

  tb_clock clock_gen_i (.clk_o(clk_i), .rst_o(rst_i));

  ccu_top ccu_top_i (.*);

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_resp(input int p, input port_resp_t exp, input port_resp_t got);
    if (exp !== got)
      fail_run($sformatf("mismatch at %0t: resp_o port %0d expected %h got %h", $time, p, exp, got));
  endtask

  task automatic check_mem(input mem_req_t exp, input mem_req_t got);
    if (exp !== got)
      fail_run($sformatf("mismatch at %0t: mem_req_o expected %h got %h", $time, exp, got));
  endtask

  task automatic check_snp(input logic [N-1:0] exp_mask, input snoop_req_t exp,
                           input logic [N-1:0] got_mask, input snoop_req_t got);
    if (exp_mask !== got_mask)
      fail_run($sformatf("mismatch at %0t: snp_valid_o expected %b got %b",
                         $time, exp_mask, got_mask));
    if (exp !== got)
      fail_run($sformatf("mismatch at %0t: snp_o expected %h got %h", $time, exp, got));
  endtask

  task automatic check_line_gone(input int p, input addr_t a);
    if (line_dirty[p].exists(a))
      fail_run($sformatf("port %0d still holds line %h after an invalidating snoop", p, a));
  endtask

  function automatic data_t mem_fill(input addr_t a);
    return data_t'(a) ^ 32'h0000_5A5A;  // Unwritten memory pattern
  endfunction

  // Predicts the response by the coherency rules and queues the expected snoop and memory traffic
  function automatic port_resp_t predict_resp(input int p, input port_req_t r);
    logic         snoop;
    logic         hit;
    data_t        d;
    snp_exp_t     e;
    logic [N-1:0] mask;
    snoop = r.write ? (r.cmd.wr == WRITE_UNIQUE) : (r.cmd.rd != READ_NO_SNOOP);
    hit   = 1'b0;
    d     = r.data;  // Writes echo their data
    if (snoop) begin
      mask    = '1;
      mask[p] = 1'b0;  // Requester is never snooped
      e.mask  = mask;
      e.req.addr = r.addr;
      if (r.write) e.req.op = AC_CLEAN_INVALID;
      else if (r.cmd.rd == READ_UNIQUE) e.req.op = AC_READ_UNIQUE;
      else e.req.op = AC_READ_SHARED;
      exp_snp.push_back(e);
      for (int q = 0; q < N; q++) begin
        if (q != p && ref_line[q].exists(r.addr)) begin
          if (!hit && !r.write) begin
            hit = 1'b1;
            d   = ref_line[q][r.addr];
          end
          if (e.req.op != AC_READ_SHARED) ref_line[q].delete(r.addr);
        end
      end
    end
    if (!hit) begin  // Misses and writes go to memory
      exp_mem.push_back('{write: r.write, addr: r.addr, data: r.data});
      if (r.write) ref_mem[r.addr] = r.data;
      else d = ref_mem.exists(r.addr) ? ref_mem[r.addr] : mem_fill(r.addr);
    end
    return '{write: r.write, data: d};
  endfunction

  function automatic port_req_t rd_req(input rd_snoop_e c, input addr_t a);
    port_req_t r;
    r        = '0;
    r.cmd.rd = c;
    r.addr   = a;
    return r;
  endfunction

  function automatic port_req_t wr_req(input wr_snoop_e c, input addr_t a, input data_t d);
    port_req_t r;
    r.write  = 1'b1;
    r.cmd.wr = c;
    r.addr   = a;
    r.data   = d;
    return r;
  endfunction

  function automatic port_req_t rand_req();
    port_req_t   r;
    int unsigned pick;
    pick    = $unsigned($random(seed)) % 5;
    r.write = (pick >= 3);
    r.addr  = 16'h0100 | addr_t'($unsigned($random(seed)) % 8);  // Small address set so lines collide
    r.data  = $random(seed);
    case (pick)
      0: r.cmd.rd = READ_NO_SNOOP;
      1: r.cmd.rd = READ_SHARED;
      2: r.cmd.rd = READ_UNIQUE;
      3: r.cmd.wr = WRITE_NO_SNOOP;
      default: r.cmd.wr = WRITE_UNIQUE;
    endcase
    return r;
  endfunction

  task automatic set_dirty(input int p, input addr_t a, input data_t d);
    line_dirty[p][a] = d;
    ref_line[p][a]   = d;
  endtask

  task automatic issue(input int p, input port_req_t r);
    stim_q[p].push_back(r);
    issued_cnt++;
  endtask

  task automatic wait_idle();
    do @(posedge clk_i); while (done_cnt != issued_cnt);
  endtask

  // Sampled on the rising edge before the registers update
  task automatic sample_outputs();
    snp_exp_t exp_e;
    if ((req_ready_o & ~req_valid_i) != '0 || $countones(req_ready_o) > 1)
      fail_run("req_ready_o is high for a port that did not win the arbitration");
    for (int p = 0; p < N; p++) begin
      if (req_valid_i[p] && req_ready_o[p]) begin
        accepted[p] = 1'b1;
        if (hold_mem && !saw_full) held_acc++;
        exp_resp[p].push_back(predict_resp(p, req_i[p]));
      end
      if (resp_valid_o[p]) begin
        if (exp_resp[p].size() == 0) begin
          fail_run($sformatf("response on port %0d with no request outstanding", p));
        end else begin
          check_resp(p, exp_resp[p].pop_front(), resp_o);
          done_cnt++;
        end
      end
    end
    if (hold_mem && !saw_full && req_valid_i != '0 && req_ready_o == '0) begin
      if (held_acc != HOLD_ACCEPTS)
        fail_run($sformatf("mismatch at %0t: req_ready_o low after %0d accepts, expected %0d",
                           $time, held_acc, HOLD_ACCEPTS));
      saw_full = 1'b1;
    end
    if (snp_valid_o != '0) begin
      if (exp_snp.size() == 0) fail_run("snoop issued where none was expected");
      exp_e = exp_snp.pop_front();
      check_snp(exp_e.mask, exp_e.req, snp_valid_o, snp_o);
      for (int p = 0; p < N; p++) begin
        if (snp_valid_o[p]) begin
          snp_next[p].has_data = line_dirty[p].exists(snp_o.addr);
          snp_next[p].data     = snp_next[p].has_data ? line_dirty[p][snp_o.addr] : '0;
          if (snp_o.op != AC_READ_SHARED) line_dirty[p].delete(snp_o.addr);
          snp_due[p] = 1'b1;
        end
      end
    end
    if (mem_valid_o && mem_ready_i) begin
      if (exp_mem.size() == 0) fail_run("memory request issued where none was expected");
      check_mem(exp_mem.pop_front(), mem_req_o);
      if (mem_req_o.write) mem_model[mem_req_o.addr] = mem_req_o.data;
      mem_rdata_q = mem_model.exists(mem_req_o.addr) ? mem_model[mem_req_o.addr]
                                                     : mem_fill(mem_req_o.addr);
      mem_due = 1'b1;
      stall   = $unsigned($random(seed)) % 4;  // Wait before the next acceptance
    end
  endtask

  // All DUT inputs change on the falling edge
  task automatic drive_inputs();
    snp_resp_valid_i = snp_due;
    snp_resp_i       = snp_next;
    snp_due          = '0;
    mem_resp_valid_i = mem_due;
    mem_rdata_i      = mem_rdata_q;
    mem_due          = 1'b0;
    mem_ready_i      = 1'b0;
    if (mem_valid_o && !hold_mem) begin
      if (stall == 0) mem_ready_i = 1'b1;
      else stall--;
    end
    for (int p = 0; p < N; p++) begin
      if (accepted[p]) stim_rd[p]++;
      accepted[p] = 1'b0;
      if (stim_rd[p] < stim_q[p].size()) begin
        req_valid_i[p] = 1'b1;
        req_i[p]       = stim_q[p][stim_rd[p]];
      end else begin
        req_valid_i[p] = 1'b0;
      end
    end
  endtask

  always begin
    @(posedge clk_i);
    if (!rst_i) sample_outputs();
    @(negedge clk_i);
    drive_inputs();
  end

  initial begin
    #(TIMEOUT_NS);
    fail_run("timeout, the DUT stopped answering requests");
  end

  initial begin
    @(negedge rst_i);
    issue(0, rd_req(READ_NO_SNOOP, 16'h0010));  // Plain read without a snoop
    wait_idle();
    issue(0, wr_req(WRITE_NO_SNOOP, 16'h0020, 32'hCAFE_0020));
    wait_idle();
    issue(1, rd_req(READ_NO_SNOOP, 16'h0020));  // Sees the other port's write
    wait_idle();
    set_dirty(1, 16'h0030, 32'hD1D1_0030);
    issue(0, rd_req(READ_SHARED, 16'h0030));    // Hit forwarded from port 1
    wait_idle();
    issue(1, rd_req(READ_SHARED, 16'h0040));
    issue(0, rd_req(READ_UNIQUE, 16'h0044));
    wait_idle();
    set_dirty(0, 16'h0050, 32'hD0D0_0050);
    issue(1, rd_req(READ_UNIQUE, 16'h0050));
    wait_idle();
    check_line_gone(0, 16'h0050);
    set_dirty(0, 16'h0060, 32'hD0D0_0060);
    set_dirty(1, 16'h0060, 32'hD1D1_0060);
    issue(1, wr_req(WRITE_UNIQUE, 16'h0060, 32'h5EED_0060));
    wait_idle();
    check_line_gone(0, 16'h0060);

    // Memory stalled while both ports keep requesting
    set_dirty(0, 16'h0102, 32'h0BAD_0102);
    set_dirty(1, 16'h0105, 32'h0BAD_0105);
    hold_mem = 1'b1;
    for (int p = 0; p < N; p++) issue(p, rd_req(READ_NO_SNOOP, 16'h0100));
    for (int k = 0; k < RAND_PER_PORT; k++) begin
      for (int p = 0; p < N; p++) issue(p, rand_req());
    end
    wait (saw_full);
    hold_mem = 1'b0;
    wait_idle();

    if (exp_snp.size() != 0 || exp_mem.size() != 0) begin
      fail_run("an expected snoop or memory request was never issued");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// ==== test/tb_clock.sv ====
// Clock and reset source for the testbench, 100 ns period
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;  // Released right after the last reset edge
  end

endmodule

// ==== hdl/ccu_top.sv ====
// Coherency unit top, arbiter feeds the request queue which feeds the FSM
// Masters connect per port, one shared memory port leaves the unit
`timescale 1ns/1ps
`include "ccu_cfg.svh"

module ccu_top (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic                 [`CCU_NUM_PORTS-1:0] req_valid_i,
  input  ccu_pkg::port_req_t   [`CCU_NUM_PORTS-1:0] req_i,
  output logic                 [`CCU_NUM_PORTS-1:0] req_ready_o,
  output logic                 [`CCU_NUM_PORTS-1:0] resp_valid_o,
  output ccu_pkg::port_resp_t                      resp_o,
  output logic                 [`CCU_NUM_PORTS-1:0] snp_valid_o,
  output ccu_pkg::snoop_req_t                      snp_o,
  input  logic                 [`CCU_NUM_PORTS-1:0] snp_resp_valid_i,
  input  ccu_pkg::snoop_resp_t [`CCU_NUM_PORTS-1:0] snp_resp_i,
  output logic                                     mem_valid_o,
  output ccu_pkg::mem_req_t                        mem_req_o,
  input  logic                                     mem_ready_i,
  input  logic                                     mem_resp_valid_i,
  input  ccu_pkg::data_t                           mem_rdata_i
);

  import ccu_pkg::*;

  logic        fifo_push;
  logic        fifo_full;
  logic        fifo_pop;
  logic        fifo_empty;
  tagged_req_t push_data;
  tagged_req_t head;

  ccu_port_arb i_port_arb (
    .clk_i, .rst_i, .req_valid_i, .req_i, .req_ready_o,
    .fifo_full_i (fifo_full),
    .push_o      (fifo_push),
    .push_data_o (push_data)
  );

  ccu_req_fifo #(.DEPTH(`CCU_FIFO_DEPTH)) i_req_fifo (
    .clk_i, .rst_i,
    .push_i      (fifo_push),
    .push_data_i (push_data),
    .full_o      (fifo_full),
    .pop_i       (fifo_pop),
    .empty_o     (fifo_empty),
    .head_o      (head)
  );

  ccu_fsm i_fsm (
    .clk_i, .rst_i,
    .empty_i (fifo_empty),
    .head_i  (head),
    .pop_o   (fifo_pop),
    .snp_valid_o, .snp_o, .snp_resp_valid_i, .snp_resp_i,
    .mem_valid_o, .mem_req_o, .mem_ready_i, .mem_resp_valid_i, .mem_rdata_i,
    .resp_valid_o, .resp_o
  );

endmodule

// ==== ccu/ccu_fsm.sv ====
// Coherency FSM, serves queued requests one at a time
// Snoops the other masters for shareable commands, falls back to memory on a miss
`timescale 1ns/1ps
`include "ccu_cfg.svh"

module ccu_fsm (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic                                     empty_i,
  input  ccu_pkg::tagged_req_t                     head_i,
  output logic                                     pop_o,
  output logic                 [`CCU_NUM_PORTS-1:0] snp_valid_o,
  output ccu_pkg::snoop_req_t                      snp_o,
  input  logic                 [`CCU_NUM_PORTS-1:0] snp_resp_valid_i,
  input  ccu_pkg::snoop_resp_t [`CCU_NUM_PORTS-1:0] snp_resp_i,
  output logic                                     mem_valid_o,
  output ccu_pkg::mem_req_t                        mem_req_o,
  input  logic                                     mem_ready_i,
  input  logic                                     mem_resp_valid_i,
  input  ccu_pkg::data_t                           mem_rdata_i,
  output logic                 [`CCU_NUM_PORTS-1:0] resp_valid_o,
  output ccu_pkg::port_resp_t                      resp_o
);

  import ccu_pkg::*;

  localparam int N = `CCU_NUM_PORTS;

  typedef enum logic [2:0] {
    S_IDLE,
    S_SNOOP,     // Broadcast to every port but the requester
    S_SNP_WAIT,  // Collect snoop responses
    S_MEM_REQ,
    S_MEM_WAIT,
    S_RESP
  } state_e;

  state_e      state_q, state_d;
  tagged_req_t req_q;  // Request in service
  data_t       data_q; // Data returned to the requester
  logic [N-1:0] pending_q, pending_d;
  logic        hit_q, hit_d;

  logic        head_snoop;
  logic [N-1:0] snp_mask;
  ac_op_e      snp_op;
  logic        snp_hit;
  data_t       snp_hit_data;

  // Decode the command through the member picked by the write bit
  assign head_snoop = head_i.req.write ? (head_i.req.cmd.wr == WRITE_UNIQUE)
                                       : (head_i.req.cmd.rd != READ_NO_SNOOP);

  always_comb begin
    if (req_q.req.write) begin
      snp_op = AC_CLEAN_INVALID;  // Invalidate other copies before the write
    end else if (req_q.req.cmd.rd == READ_UNIQUE) begin
      snp_op = AC_READ_UNIQUE;
    end else begin
      snp_op = AC_READ_SHARED;
    end
  end

  assign snp_mask = ~(N'(1) << req_q.src);

  // First dirty responder wins
  always_comb begin
    snp_hit      = 1'b0;
    snp_hit_data = '0;
    for (int i = 0; i < N; i++) begin
      if (!snp_hit && snp_resp_valid_i[i] && snp_resp_i[i].has_data) begin
        snp_hit      = 1'b1;
        snp_hit_data = snp_resp_i[i].data;
      end
    end
  end

  always_comb begin
    state_d   = state_q;
    pending_d = pending_q;
    hit_d     = hit_q;
    pop_o     = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (!empty_i) begin
          pop_o   = 1'b1;
          state_d = head_snoop ? S_SNOOP : S_MEM_REQ;
        end
      end
      S_SNOOP: begin
        pending_d = snp_mask;
        hit_d     = 1'b0;
        state_d   = S_SNP_WAIT;
      end
      S_SNP_WAIT: begin
        pending_d = pending_q & ~snp_resp_valid_i;
        if (snp_hit && !req_q.req.write) hit_d = 1'b1;
        // Wait for every snooped port, invalidations included
        if (pending_d == '0) state_d = hit_d ? S_RESP : S_MEM_REQ;
      end
      S_MEM_REQ:  if (mem_ready_i) state_d = S_MEM_WAIT;
      S_MEM_WAIT: if (mem_resp_valid_i) state_d = S_RESP;
      S_RESP:     state_d = S_IDLE;
      default:    state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= S_IDLE;
      pending_q <= '0;
      hit_q     <= 1'b0;
    end else begin
      state_q   <= state_d;
      pending_q <= pending_d;
      hit_q     <= hit_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      req_q  <= head_i;
      data_q <= head_i.req.data;  // Echoed back on writes
    end else if (state_q == S_SNP_WAIT && snp_hit && !hit_q && !req_q.req.write) begin
      data_q <= snp_hit_data;
    end else if (state_q == S_MEM_WAIT && mem_resp_valid_i && !req_q.req.write) begin
      data_q <= mem_rdata_i;
    end
  end

  assign snp_valid_o  = (state_q == S_SNOOP) ? snp_mask : '0;
  assign snp_o        = '{op: snp_op, addr: req_q.req.addr};
  assign mem_valid_o  = (state_q == S_MEM_REQ);  // Held until memory takes it
  assign mem_req_o    = '{write: req_q.req.write, addr: req_q.req.addr, data: req_q.req.data};
  assign resp_valid_o = (state_q == S_RESP) ? (N'(1) << req_q.src) : '0;
  assign resp_o       = '{write: req_q.req.write, data: data_q};

  // Masters answer only snoops still owed, memory answers only an accepted request
  a_snp_resp_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    (snp_resp_valid_i & ~pending_q) == '0);
  a_mem_resp_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_resp_valid_i |-> state_q == S_MEM_WAIT);

endmodule

// ==== ccu/ccu_req_fifo.sv ====
// Request queue between the port arbiter and the coherency FSM
// Circular buffer, a pushed word shows at the head one cycle later
`timescale 1ns/1ps
`include "ccu_cfg.svh"

module ccu_req_fifo #(
  parameter int DEPTH = `CCU_FIFO_DEPTH
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 push_i,
  input  ccu_pkg::tagged_req_t push_data_i,
  output logic                 full_o,
  input  logic                 pop_i,
  output logic                 empty_o,
  output ccu_pkg::tagged_req_t head_o
);

  import ccu_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  tagged_req_t   mem_q [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q;
  logic          do_push;
  logic          do_pop;

  assign full_o  = (count_q == (AW+1)'(DEPTH));
  assign empty_o = (count_q == '0);
  assign head_o  = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (int'(wr_ptr_q) == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= (int'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + (AW+1)'(do_push) - (AW+1)'(do_pop);  // Both may happen at once
    end
  end

  // Arbiter must honour full, FSM must honour empty
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i) !(push_i && full_o));
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i) !(pop_i && empty_o));

endmodule

// ==== ccu/ccu_port_arb.sv ====
// Round-robin arbiter between the master ports
// Accepts at most one request per cycle and tags it with the winning port index
`timescale 1ns/1ps
`include "ccu_cfg.svh"

module ccu_port_arb (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic                [`CCU_NUM_PORTS-1:0] req_valid_i,
  input  ccu_pkg::port_req_t  [`CCU_NUM_PORTS-1:0] req_i,
  output logic                [`CCU_NUM_PORTS-1:0] req_ready_o,
  input  logic                                    fifo_full_i,
  output logic                                    push_o,
  output ccu_pkg::tagged_req_t                    push_data_o
);

  localparam int N  = `CCU_NUM_PORTS;
  localparam int PW = `CCU_PORT_W;

  logic [PW-1:0] prio_q;  // Port checked first this cycle
  logic [PW-1:0] win_idx;
  logic          win_found;

  // Scan ports starting at the priority pointer
  always_comb begin
    int unsigned idx;
    win_found = 1'b0;
    win_idx   = '0;
    for (int k = 0; k < N; k++) begin
      idx = (int'(prio_q) + k) % N;
      if (!win_found && req_valid_i[idx]) begin
        win_found = 1'b1;
        win_idx   = PW'(idx);
      end
    end
  end

  assign push_o = win_found && !fifo_full_i;

  // Only the winner sees ready, nobody while the queue is full
  always_comb begin
    req_ready_o          = '0;
    req_ready_o[win_idx] = push_o;
  end

  assign push_data_o.req = req_i[win_idx];
  assign push_data_o.src = win_idx;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q <= '0;
    end else if (push_o) begin
      prio_q <= (int'(win_idx) == N - 1) ? '0 : win_idx + 1'b1;  // Rotate past the winner
    end
  end

endmodule

// ==== common/ccu_pkg.sv ====
// Shared types of the coherency unit, imported by the RTL and the testbench
`include "ccu_cfg.svh"

package ccu_pkg;

  typedef logic [`CCU_ADDR_W-1:0] addr_t;
  typedef logic [`CCU_DATA_W-1:0] data_t;
  typedef logic [`CCU_PORT_W-1:0] port_idx_t;

  // Read side snoop command, codes follow ARSNOOP
  typedef enum logic [2:0] {
    READ_NO_SNOOP = 3'b000,
    READ_SHARED   = 3'b001,
    READ_UNIQUE   = 3'b111
  } rd_snoop_e;

  // Write side snoop command
  typedef enum logic [2:0] {
    WRITE_NO_SNOOP = 3'b000,
    WRITE_UNIQUE   = 3'b001
  } wr_snoop_e;

  // Same three bits, meaning picked by the write flag
  typedef union packed {
    rd_snoop_e rd;
    wr_snoop_e wr;
  } ace_cmd_u;

  // Snoop operation on the AC channel, ACSNOOP codes
  typedef enum logic [3:0] {
    AC_READ_SHARED   = 4'b0001,
    AC_READ_UNIQUE   = 4'b0111,
    AC_CLEAN_INVALID = 4'b1001
  } ac_op_e;

  typedef struct packed {
    logic     write;
    ace_cmd_u cmd;
    addr_t    addr;
    data_t    data;  // Write data, unused on reads
  } port_req_t;

  typedef struct packed {
    port_req_t req;
    port_idx_t src;  // Port that issued the request
  } tagged_req_t;

  typedef struct packed {
    logic  write;
    data_t data;
  } port_resp_t;

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
  } mem_req_t;

  typedef struct packed {
    ac_op_e op;
    addr_t  addr;
  } snoop_req_t;

  typedef struct packed {
    logic  has_data;  // Master held the line dirty
    data_t data;
  } snoop_resp_t;

endpackage

// ==== common/ccu_cfg.svh ====
// Build-time sizing of the coherency unit
// Included by the package and by every RTL module that sizes ports from it
`ifndef CCU_CFG_SVH
`define CCU_CFG_SVH

// Number of cache masters sharing the memory port
`define CCU_NUM_PORTS 2

`define CCU_ADDR_W 16    // Line address bits
`define CCU_DATA_W 32    // One beat per transaction
`define CCU_FIFO_DEPTH 4 // Accepted requests waiting for the FSM

// Port index width, kept at least one bit wide
`define CCU_PORT_W ((`CCU_NUM_PORTS > 1) ? $clog2(`CCU_NUM_PORTS) : 1)

`endif
